// File: design/lms_sample_pkg.sv
// LMS sample widths and I/Q phase
package lms_sample_pkg;

   // Converter word on the LMS6002D data bus
   localparam int LMS_SAMPLE_W = 12;

   // Receive sample width toward the DSP core
   localparam int RX_CORE_W = 14;

   // Transmit sample width from the DSP core
   // Only the low converter bits reach the pins
   localparam int TX_CORE_W = 16;

   // Meaning of the IQSEL strobe on both directions
   typedef enum logic
   {
      PHASE_I = 1'b0,  // IQSEL low carries I
      PHASE_Q = 1'b1   // IQSEL high carries Q
   } iq_phase_e;

endpackage

// File: design/board_ctrl_pkg.sv
// Board control constants
package board_ctrl_pkg;

   // Five front-panel LEDs plus the Ethernet LED on top
   localparam int LED_COUNT = 6;

   // Set bits are driven low to light the LED
   // Ethernet LED is active high, so its bit stays clear
   localparam logic [LED_COUNT-1:0] LED_ACTIVE_LOW_MASK = 6'b011111;

   // Clock-ready samples kept for the PLL reset decision
   localparam int READY_HISTORY_DEPTH = 6;

endpackage

// File: design/rx_iq_demux.sv
// Receive I/Q demultiplexer
`timescale 1ns/1ps

module rx_iq_demux
   import lms_sample_pkg::*;
#(
   parameter int SAMPLE_W = LMS_SAMPLE_W
)
(
   input  logic                 dsp_clk,
   input  logic                 reset_i,
   input  logic [SAMPLE_W-1:0]  rx_d_i,
   input  logic                 rx_iqsel_i,
   output logic [RX_CORE_W-1:0] adc_i_o,
   output logic [RX_CORE_W-1:0] adc_q_o
);

   iq_phase_e            rx_phase;
   logic [RX_CORE_W-1:0] rx_word;

   assign rx_phase = iq_phase_e'(rx_iqsel_i);
   assign rx_word  = RX_CORE_W'(rx_d_i);  // Zero-extend to core width

   // One register per component, the other one holds
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         adc_i_o <= '0;
         adc_q_o <= '0;
      end
      else
      begin
         case (rx_phase)
            PHASE_I: adc_i_o <= rx_word;
            PHASE_Q: adc_q_o <= rx_word;
            default: ;
         endcase
      end
   end

   // I may only move after a word tagged as I
   i_changes_on_i_phase: assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      (!$past(reset_i) && !$stable(adc_i_o)) |-> ($past(rx_phase) == PHASE_I)
   );

   // Same for Q
   q_changes_on_q_phase: assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      (!$past(reset_i) && !$stable(adc_q_o)) |-> ($past(rx_phase) == PHASE_Q)
   );

endmodule

// File: design/tx_iq_interleave.sv
// Transmit I/Q interleaver
`timescale 1ns/1ps

module tx_iq_interleave
   import lms_sample_pkg::*;
#(
   parameter int SAMPLE_W = LMS_SAMPLE_W
)
(
   input  logic                 dsp_clk,
   input  logic                 reset_i,
   input  logic [TX_CORE_W-1:0] dac_i_i,
   input  logic [TX_CORE_W-1:0] dac_q_i,
   output logic [SAMPLE_W-1:0]  tx_d_o,
   output logic                 tx_iqsel_o
);

   iq_phase_e tx_phase;  // Component sent at the coming edge

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         tx_phase   <= PHASE_I;
         tx_d_o     <= '0;
         tx_iqsel_o <= 1'b0;
      end
      else
      begin
         case (tx_phase)
            PHASE_I:
            begin
               tx_d_o   <= dac_i_i[SAMPLE_W-1:0];  // Upper core bits dropped
               tx_phase <= PHASE_Q;
            end
            PHASE_Q:
            begin
               tx_d_o   <= dac_q_i[SAMPLE_W-1:0];
               tx_phase <= PHASE_I;
            end
            default: tx_phase <= PHASE_I;
         endcase
         tx_iqsel_o <= tx_phase;  // IQSEL tags the word just registered
      end
   end

   // First word out of reset is I with IQSEL low, like the reset value,
   // so alternation is only checked from the second word on
   iqsel_alternates: assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      (!$past(reset_i) && !$past(reset_i, 2)) |-> (tx_iqsel_o != $past(tx_iqsel_o))
   );

endmodule

// File: design/spi_fanout.sv
// SPI bus fan-out to LMS chips and DAC
`timescale 1ns/1ps

module spi_fanout
(
   input  logic dsp_clk,
   input  logic sclk_i,
   input  logic mosi_i,
   input  logic sen_lms1_i,   // Active low
   input  logic sen_lms2_i,   // Active low
   input  logic sen_dac_i,    // Active low
   input  logic miso_lms1_i,
   input  logic miso_lms2_i,
   input  logic miso_dac_i,
   output logic sclk_lms1_o,
   output logic mosi_lms1_o,
   output logic sclk_lms2_o,
   output logic mosi_lms2_o,
   output logic sclk_dac_o,
   output logic miso_o
);

   // LMS chips share MOSI, so idle chips see a quiet bus
   assign sclk_lms1_o = ~sen_lms1_i & sclk_i;
   assign mosi_lms1_o = ~sen_lms1_i & mosi_i;
   assign sclk_lms2_o = ~sen_lms2_i & sclk_i;
   assign mosi_lms2_o = ~sen_lms2_i & mosi_i;

   assign sclk_dac_o = sclk_i;  // DAC ignores the clock without its select

   // Unselected devices do not float into the merge
   assign miso_o = (~sen_lms1_i & miso_lms1_i) |
                   (~sen_lms2_i & miso_lms2_i) |
                   (~sen_dac_i  & miso_dac_i);

   // Master must address one device at a time
   single_select: assert property (
      @(posedge dsp_clk) $onehot0({~sen_lms1_i, ~sen_lms2_i, ~sen_dac_i})
   );

endmodule

// File: design/board_ctrl.sv
// PLL reset, LMS reset and LED control
`timescale 1ns/1ps

module board_ctrl
   import board_ctrl_pkg::*;
#(
   parameter int HISTORY_DEPTH = READY_HISTORY_DEPTH
)
(
   input  logic                 dsp_clk,
   input  logic                 reset_i,
   input  logic                 clock_ready_i,
   input  logic [LED_COUNT-1:0] leds_i,
   output logic                 pll_rst_o,
   output logic                 lms_nrst_o,
   output logic [LED_COUNT-1:0] leds_o
);

   logic [HISTORY_DEPTH-1:0] ready_hist;
   logic [HISTORY_DEPTH-1:0] ready_hist_next;
   logic                     ready_mixed;

   assign ready_hist_next = {ready_hist[HISTORY_DEPTH-2:0], clock_ready_i};

   // Neither settled high nor settled low
   assign ready_mixed = (|ready_hist_next) & ~(&ready_hist_next);

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         ready_hist <= '0;
         pll_rst_o  <= 1'b0;
         lms_nrst_o <= 1'b0;                 // Hold both LMS chips in reset
         leds_o     <= LED_ACTIVE_LOW_MASK;  // All LEDs dark
      end
      else
      begin
         ready_hist <= ready_hist_next;
         pll_rst_o  <= ready_mixed;
         lms_nrst_o <= 1'b1;
         leds_o     <= leds_i ^ LED_ACTIVE_LOW_MASK;
      end
   end

   // PLL reset request must track the stored history
   pll_rst_needs_mixed: assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      pll_rst_o |-> ((|ready_hist) && !(&ready_hist))
   );

endmodule

// File: design/lms_frontend_top.sv
// LMS6002D front-end adapter
`timescale 1ns/1ps

module lms_frontend_top
   import lms_sample_pkg::*;
   import board_ctrl_pkg::*;
#(
   parameter int SAMPLE_W      = LMS_SAMPLE_W,
   parameter int HISTORY_DEPTH = READY_HISTORY_DEPTH
)
(
   input  logic                 dsp_clk,
   input  logic                 reset_i,

   // Receive data from both LMS chips
   input  logic [SAMPLE_W-1:0]  rx1_d_i,
   input  logic [SAMPLE_W-1:0]  rx2_d_i,
   input  logic                 rx1_iqsel_i,
   input  logic                 rx2_iqsel_i,
   output logic [RX_CORE_W-1:0] adc1_i_o,
   output logic [RX_CORE_W-1:0] adc1_q_o,
   output logic [RX_CORE_W-1:0] adc2_i_o,
   output logic [RX_CORE_W-1:0] adc2_q_o,

   // Transmit data toward both LMS chips
   input  logic [TX_CORE_W-1:0] dac1_i_i,
   input  logic [TX_CORE_W-1:0] dac1_q_i,
   input  logic [TX_CORE_W-1:0] dac2_i_i,
   input  logic [TX_CORE_W-1:0] dac2_q_i,
   output logic [SAMPLE_W-1:0]  tx1_d_o,
   output logic [SAMPLE_W-1:0]  tx2_d_o,
   output logic                 tx1_iqsel_o,
   output logic                 tx2_iqsel_o,

   // SPI
   input  logic                 sclk_i,
   input  logic                 mosi_i,
   input  logic                 sen_lms1_i,
   input  logic                 sen_lms2_i,
   input  logic                 sen_dac_i,
   input  logic                 miso_lms1_i,
   input  logic                 miso_lms2_i,
   input  logic                 miso_dac_i,
   output logic                 sclk_lms1_o,
   output logic                 mosi_lms1_o,
   output logic                 sclk_lms2_o,
   output logic                 mosi_lms2_o,
   output logic                 sclk_dac_o,
   output logic                 miso_o,

   // Board status
   input  logic                 clock_ready_i,
   input  logic [LED_COUNT-1:0] leds_i,
   output logic                 pll_rst_o,
   output logic                 lms1_nrst_o,
   output logic                 lms2_nrst_o,
   output logic [LED_COUNT-1:0] leds_o
);

   logic lms_nrst;  // Shared release for both transceivers

   rx_iq_demux #(.SAMPLE_W(SAMPLE_W)) u_rx1 (
      .dsp_clk    (dsp_clk),
      .reset_i    (reset_i),
      .rx_d_i     (rx1_d_i),
      .rx_iqsel_i (rx1_iqsel_i),
      .adc_i_o    (adc1_i_o),
      .adc_q_o    (adc1_q_o)
   );

   rx_iq_demux #(.SAMPLE_W(SAMPLE_W)) u_rx2 (
      .dsp_clk    (dsp_clk),
      .reset_i    (reset_i),
      .rx_d_i     (rx2_d_i),
      .rx_iqsel_i (rx2_iqsel_i),
      .adc_i_o    (adc2_i_o),
      .adc_q_o    (adc2_q_o)
   );

   // Common reset keeps the two TX phases in step
   tx_iq_interleave #(.SAMPLE_W(SAMPLE_W)) u_tx1 (
      .dsp_clk    (dsp_clk),
      .reset_i    (reset_i),
      .dac_i_i    (dac1_i_i),
      .dac_q_i    (dac1_q_i),
      .tx_d_o     (tx1_d_o),
      .tx_iqsel_o (tx1_iqsel_o)
   );

   tx_iq_interleave #(.SAMPLE_W(SAMPLE_W)) u_tx2 (
      .dsp_clk    (dsp_clk),
      .reset_i    (reset_i),
      .dac_i_i    (dac2_i_i),
      .dac_q_i    (dac2_q_i),
      .tx_d_o     (tx2_d_o),
      .tx_iqsel_o (tx2_iqsel_o)
   );

   spi_fanout u_spi (
      .dsp_clk     (dsp_clk),
      .sclk_i      (sclk_i),
      .mosi_i      (mosi_i),
      .sen_lms1_i  (sen_lms1_i),
      .sen_lms2_i  (sen_lms2_i),
      .sen_dac_i   (sen_dac_i),
      .miso_lms1_i (miso_lms1_i),
      .miso_lms2_i (miso_lms2_i),
      .miso_dac_i  (miso_dac_i),
      .sclk_lms1_o (sclk_lms1_o),
      .mosi_lms1_o (mosi_lms1_o),
      .sclk_lms2_o (sclk_lms2_o),
      .mosi_lms2_o (mosi_lms2_o),
      .sclk_dac_o  (sclk_dac_o),
      .miso_o      (miso_o)
   );

   board_ctrl #(.HISTORY_DEPTH(HISTORY_DEPTH)) u_board (
      .dsp_clk       (dsp_clk),
      .reset_i       (reset_i),
      .clock_ready_i (clock_ready_i),
      .leds_i        (leds_i),
      .pll_rst_o     (pll_rst_o),
      .lms_nrst_o    (lms_nrst),
      .leds_o        (leds_o)
   );

   assign lms1_nrst_o = lms_nrst;
   assign lms2_nrst_o = lms_nrst;

endmodule

// File: testbench/tb_lms_frontend.sv
// LMS front-end testbench
`timescale 1ns/1ps

module tb_lms_frontend
   import lms_sample_pkg::*;
   import board_ctrl_pkg::*;
;

   localparam int RESET_CYCLES   = 16;
   localparam int RUN_CYCLES     = 2384;
   localparam int DRAIN_CYCLES   = 8;
   localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + RUN_CYCLES) + 200;

   localparam logic [15:0] LFSR_SEED = 16'd38585;
   localparam logic [LED_COUNT-1:0] LED_MASK = 6'b011111;  // Five front-panel LEDs active low

   logic                 dsp_clk;
   logic                 reset_i;
   logic [LMS_SAMPLE_W-1:0] rx1_d_i;
   logic [LMS_SAMPLE_W-1:0] rx2_d_i;
   logic                 rx1_iqsel_i;
   logic                 rx2_iqsel_i;
   logic [RX_CORE_W-1:0] adc1_i_o;
   logic [RX_CORE_W-1:0] adc1_q_o;
   logic [RX_CORE_W-1:0] adc2_i_o;
   logic [RX_CORE_W-1:0] adc2_q_o;
   logic [TX_CORE_W-1:0] dac1_i_i;
   logic [TX_CORE_W-1:0] dac1_q_i;
   logic [TX_CORE_W-1:0] dac2_i_i;
   logic [TX_CORE_W-1:0] dac2_q_i;
   logic [LMS_SAMPLE_W-1:0] tx1_d_o;
   logic [LMS_SAMPLE_W-1:0] tx2_d_o;
   logic                 tx1_iqsel_o;
   logic                 tx2_iqsel_o;
   logic sclk_i, mosi_i;
   logic sen_lms1_i, sen_lms2_i, sen_dac_i;
   logic miso_lms1_i, miso_lms2_i, miso_dac_i;
   logic sclk_lms1_o, mosi_lms1_o, sclk_lms2_o, mosi_lms2_o, sclk_dac_o, miso_o;
   logic                 clock_ready_i;
   logic [LED_COUNT-1:0] leds_i;
   logic                 pll_rst_o;
   logic                 lms1_nrst_o;
   logic                 lms2_nrst_o;
   logic [LED_COUNT-1:0] leds_o;

   // Reference model state
   logic [RX_CORE_W-1:0] exp_adc1_i, exp_adc1_q, exp_adc2_i, exp_adc2_q;
   iq_phase_e            exp_phase;
   logic [LMS_SAMPLE_W-1:0] exp_tx1_d, exp_tx2_d;
   logic                 exp_tx_iqsel;
   logic [5:0]           exp_hist;
   logic                 exp_pll_rst;
   logic                 exp_nrst;
   logic [LED_COUNT-1:0] exp_leds;
   logic [5:0]           exp_spi;
   logic [5:0]           spi_out;

   logic [15:0] lfsr_state;
   logic        checks_armed;
   int          cycle_count;
   int          ready_run_left;

   lms_frontend_top uut (.*);

   always #5 dsp_clk = ~dsp_clk;

   // Taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int k = 0; k < count; k++)
      begin
         fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         bits = {bits[30:0], fb};
      end
      return bits;
   endfunction

   task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("FAIL %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
      $display("Regression failed");
      $fatal(1, "Stopping at first mismatch");
   endtask

   // One random cycle on every input group
   task automatic drive_random_cycle();
      logic [1:0] sel;
      rx1_d_i     <= LMS_SAMPLE_W'(random_bits(LMS_SAMPLE_W));
      rx1_iqsel_i <= random_bits(1) != 0;
      rx2_d_i     <= LMS_SAMPLE_W'(random_bits(LMS_SAMPLE_W));
      rx2_iqsel_i <= random_bits(1) != 0;
      dac1_i_i    <= TX_CORE_W'(random_bits(TX_CORE_W));
      dac1_q_i    <= TX_CORE_W'(random_bits(TX_CORE_W));
      dac2_i_i    <= TX_CORE_W'(random_bits(TX_CORE_W));
      dac2_q_i    <= TX_CORE_W'(random_bits(TX_CORE_W));
      sel = 2'(random_bits(2));  // 0 idle, 1 LMS1, 2 LMS2, 3 DAC
      sen_lms1_i  <= (sel != 2'd1);
      sen_lms2_i  <= (sel != 2'd2);
      sen_dac_i   <= (sel != 2'd3);
      sclk_i      <= random_bits(1) != 0;
      mosi_i      <= random_bits(1) != 0;
      miso_lms1_i <= random_bits(1) != 0;
      miso_lms2_i <= random_bits(1) != 0;
      miso_dac_i  <= random_bits(1) != 0;
      leds_i      <= LED_COUNT'(random_bits(LED_COUNT));
      if (ready_run_left == 0)
      begin
         clock_ready_i  <= random_bits(1) != 0;
         ready_run_left = int'(random_bits(3)) + 1;  // Runs of 1 to 8 cycles
      end
      ready_run_left = ready_run_left - 1;
   endtask

   // Registered models fed by the inputs seen at each edge
   always @(posedge dsp_clk)
   begin : seq_model
      logic [5:0] hist_next;
      hist_next = {exp_hist[4:0], clock_ready_i};
      if (reset_i)
      begin
         exp_adc1_i   <= '0;
         exp_adc1_q   <= '0;
         exp_adc2_i   <= '0;
         exp_adc2_q   <= '0;
         exp_phase    <= PHASE_I;
         exp_tx1_d    <= '0;
         exp_tx2_d    <= '0;
         exp_tx_iqsel <= 1'b0;
         exp_hist     <= '0;
         exp_pll_rst  <= 1'b0;
         exp_leds     <= LED_MASK;
      end
      else
      begin
         if (rx1_iqsel_i)
            exp_adc1_q <= {2'b00, rx1_d_i};
         else
            exp_adc1_i <= {2'b00, rx1_d_i};
         if (rx2_iqsel_i)
            exp_adc2_q <= {2'b00, rx2_d_i};
         else
            exp_adc2_i <= {2'b00, rx2_d_i};
         exp_tx1_d    <= (exp_phase == PHASE_I) ? dac1_i_i[11:0] : dac1_q_i[11:0];
         exp_tx2_d    <= (exp_phase == PHASE_I) ? dac2_i_i[11:0] : dac2_q_i[11:0];
         exp_tx_iqsel <= (exp_phase == PHASE_Q);
         exp_phase    <= (exp_phase == PHASE_I) ? PHASE_Q : PHASE_I;
         exp_hist     <= hist_next;
         exp_pll_rst  <= (hist_next != 6'b000000) && (hist_next != 6'b111111);
         exp_leds     <= leds_i ^ LED_MASK;
      end
      exp_nrst <= !reset_i;
   end

   // Bit order matches spi_out
   always_comb
   begin
      exp_spi    = '0;
      exp_spi[1] = sclk_i;  // DAC clock is never gated
      if (!sen_lms1_i)
      begin
         exp_spi[5] = sclk_i;
         exp_spi[4] = mosi_i;
         exp_spi[0] = miso_lms1_i;
      end
      if (!sen_lms2_i)
      begin
         exp_spi[3] = sclk_i;
         exp_spi[2] = mosi_i;
         exp_spi[0] = miso_lms2_i;
      end
      if (!sen_dac_i)
         exp_spi[0] = miso_dac_i;
   end

   assign spi_out = {sclk_lms1_o, mosi_lms1_o, sclk_lms2_o, mosi_lms2_o, sclk_dac_o, miso_o};

   rx1_i_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      adc1_i_o == exp_adc1_i)
      else report_mismatch("rx_demux ch1 I", 32'($sampled(exp_adc1_i)), 32'($sampled(adc1_i_o)));
   rx1_q_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      adc1_q_o == exp_adc1_q)
      else report_mismatch("rx_demux ch1 Q", 32'($sampled(exp_adc1_q)), 32'($sampled(adc1_q_o)));
   rx2_i_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      adc2_i_o == exp_adc2_i)
      else report_mismatch("rx_demux ch2 I", 32'($sampled(exp_adc2_i)), 32'($sampled(adc2_i_o)));
   rx2_q_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      adc2_q_o == exp_adc2_q)
      else report_mismatch("rx_demux ch2 Q", 32'($sampled(exp_adc2_q)), 32'($sampled(adc2_q_o)));

   tx1_data_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      tx1_d_o == exp_tx1_d)
      else report_mismatch("tx_interleave ch1 data", 32'($sampled(exp_tx1_d)),
                           32'($sampled(tx1_d_o)));
   tx2_data_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      tx2_d_o == exp_tx2_d)
      else report_mismatch("tx_interleave ch2 data", 32'($sampled(exp_tx2_d)),
                           32'($sampled(tx2_d_o)));
   tx_iqsel_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      tx1_iqsel_o == exp_tx_iqsel && tx2_iqsel_o == exp_tx_iqsel)
      else report_mismatch("tx_interleave iqsel", 32'($sampled({exp_tx_iqsel, exp_tx_iqsel})),
                           32'($sampled({tx2_iqsel_o, tx1_iqsel_o})));

   spi_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      spi_out == exp_spi)
      else report_mismatch("spi_fanout", 32'($sampled(exp_spi)), 32'($sampled(spi_out)));

   pll_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      pll_rst_o == exp_pll_rst)
      else report_mismatch("pll_reset", 32'($sampled(exp_pll_rst)), 32'($sampled(pll_rst_o)));

   nrst_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      lms1_nrst_o == exp_nrst && lms2_nrst_o == exp_nrst)
      else report_mismatch("status_outputs lms reset", 32'($sampled({exp_nrst, exp_nrst})),
                           32'($sampled({lms2_nrst_o, lms1_nrst_o})));
   leds_check: assert property (@(posedge dsp_clk) disable iff (!checks_armed)
      leds_o == exp_leds)
      else report_mismatch("status_outputs leds", 32'($sampled(exp_leds)), 32'($sampled(leds_o)));

   always @(posedge dsp_clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Regression failed");
         $fatal(1, "Stopping on timeout");
      end
   end

   initial
   begin
      dsp_clk        = 1'b0;
      reset_i        = 1'b1;
      lfsr_state     = LFSR_SEED;
      checks_armed   = 1'b0;
      cycle_count    = 0;
      ready_run_left = 0;
      rx1_d_i        = '0;
      rx2_d_i        = '0;
      rx1_iqsel_i    = 1'b0;
      rx2_iqsel_i    = 1'b0;
      dac1_i_i       = '0;
      dac1_q_i       = '0;
      dac2_i_i       = '0;
      dac2_q_i       = '0;
      sclk_i         = 1'b0;
      mosi_i         = 1'b0;
      sen_lms1_i     = 1'b1;
      sen_lms2_i     = 1'b1;
      sen_dac_i      = 1'b1;
      miso_lms1_i    = 1'b0;
      miso_lms2_i    = 1'b0;
      miso_dac_i     = 1'b0;
      clock_ready_i  = 1'b0;
      leds_i         = '0;

      repeat (2) @(posedge dsp_clk);
      checks_armed <= 1'b1;  // Outputs hold reset values by now
      repeat (RESET_CYCLES - 2) @(posedge dsp_clk);
      reset_i <= 1'b0;

      for (int n = 0; n < RUN_CYCLES; n++)
      begin
         drive_random_cycle();
         @(posedge dsp_clk);
      end
      repeat (DRAIN_CYCLES) @(posedge dsp_clk);
      @(negedge dsp_clk);

      $display("Regression passed");
      $finish;
   end

endmodule

// File: sources.f
design/lms_sample_pkg.sv
design/board_ctrl_pkg.sv
design/rx_iq_demux.sv
design/tx_iq_interleave.sv
design/spi_fanout.sv
design/board_ctrl.sv
design/lms_frontend_top.sv
testbench/tb_lms_frontend.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_lms_frontend
FILELIST  := sources.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SIM_LOG   := sim.log
PASS_MSG  := Regression passed
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(SIM_LOG)
	@grep -q "^$(PASS_MSG)$$" $(SIM_LOG) || { echo "Simulation failed, see $(SIM_LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
